/* bp_pkg.sv */
/*
 * Shared definitions for the fetch-side branch predictor.
 * Address field widths, the instruction address union and the
 * direction counter start values. Files refer to them by scoped name.
 */

package bp_pkg;

	// Word-aligned 32-bit instruction address split
	localparam int TAG_W    = 27;
	localparam int INDEX_W  = 3;
	localparam int OFFSET_W = 2;

	// Sets in the target cache
	localparam int NUM_SETS = 1 << INDEX_W;

	// Counter value given to a freshly allocated entry
	localparam logic [1:0] CNT_WEAK_TAKEN = 2'd2;
	localparam logic [1:0] CNT_WEAK_NOT   = 2'd1;

	// Instruction address, as a raw word or as cache fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [TAG_W-1:0]    tag;
			logic [INDEX_W-1:0]  index;
			logic [OFFSET_W-1:0] offset;
		} f;
	} fetch_addr_u;

endpackage

/* branch_predict_top.sv */
/*
 * Branch prediction subsystem top level.
 * Execute trains the target cache through the update queue; fetch
 * searches it and gets the predicted next address one cycle later.
 */

`timescale 1ns/1ps

module branch_predict_top #(
	parameter int LRU_TIMER_N = 8,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        flush,
	input  logic        update_valid,
	input  logic [31:0] update_inst_addr,
	input  logic [31:0] update_target,
	input  logic        update_taken,
	output logic        update_ready,
	input  logic        search_stb,
	input  logic [31:0] search_addr,
	output logic        pred_valid,
	output logic        pred_hit,
	output logic        pred_taken,
	output logic [31:0] pred_next_addr
);

	// Queue to cache
	logic        wr_stb;
	logic [31:0] wr_inst_addr;
	logic [31:0] wr_target;
	logic        wr_taken;

	// Cache to selector
	logic        hit_q;
	logic        taken_q;
	logic [31:0] target_q;

	branch_update_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.iCLOCK           (iCLOCK),
		.inRESET          (inRESET),
		.flush            (flush),
		.update_valid     (update_valid),
		.update_inst_addr (update_inst_addr),
		.update_target    (update_target),
		.update_taken     (update_taken),
		.update_ready     (update_ready),
		.wr_stb           (wr_stb),
		.wr_inst_addr     (wr_inst_addr),
		.wr_target        (wr_target),
		.wr_taken         (wr_taken)
	);

	branch_target_cache #(
		.LRU_TIMER_N (LRU_TIMER_N)
	) u_cache (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.flush        (flush),
		.wr_stb       (wr_stb),
		.wr_inst_addr (wr_inst_addr),
		.wr_target    (wr_target),
		.wr_taken     (wr_taken),
		.search_stb   (search_stb),
		.search_addr  (search_addr),
		.hit_q        (hit_q),
		.taken_q      (taken_q),
		.target_q     (target_q)
	);

	next_fetch_select u_select (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.search_stb     (search_stb),
		.search_addr    (search_addr),
		.hit_q          (hit_q),
		.taken_q        (taken_q),
		.target_q       (target_q),
		.pred_valid     (pred_valid),
		.pred_hit       (pred_hit),
		.pred_taken     (pred_taken),
		.pred_next_addr (pred_next_addr)
	);

endmodule

/* branch_target_cache.sv */
/*
 * Two-way, eight-set branch target cache.
 * Trained by the update queue strobe, searched by fetch; the search
 * result comes out registered one cycle later. Each way keeps a tag,
 * a 2-bit direction counter, a target and a 2-bit LRU rank (0 = invalid).
 */

`timescale 1ns/1ps

module branch_target_cache #(
	parameter int LRU_TIMER_N = 8
) (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        flush,
	input  logic        wr_stb,
	input  logic [31:0] wr_inst_addr,
	input  logic [31:0] wr_target,
	input  logic        wr_taken,
	input  logic        search_stb,
	input  logic [31:0] search_addr,
	output logic        hit_q,
	output logic        taken_q,
	output logic [31:0] target_q
);

	localparam int TAG_W    = bp_pkg::TAG_W;
	localparam int INDEX_W  = bp_pkg::INDEX_W;
	localparam int NUM_SETS = bp_pkg::NUM_SETS;

	// Per-way storage, first index is the way
	logic [TAG_W-1:0] tag_mem    [2][NUM_SETS];
	logic [1:0]       cnt_mem    [2][NUM_SETS];
	logic [31:0]      target_mem [2][NUM_SETS];
	logic [1:0]       rank_mem   [2][NUM_SETS];

	logic [LRU_TIMER_N-1:0] lru_timer;
	logic                   age;

	bp_pkg::fetch_addr_u wr_a;
	bp_pkg::fetch_addr_u sr_a;
	logic [INDEX_W-1:0]  widx;
	logic [INDEX_W-1:0]  sidx;

	logic       wr_hit0;
	logic       wr_hit1;
	logic       wr_match;
	logic       wr_way;
	logic [1:0] wr_cnt;
	logic       s_hit0;
	logic       s_hit1;
	logic       s_hit;
	logic       s_way;
	logic       same_set;

	// Saturating direction counter step
	function automatic logic [1:0] cnt_step(input logic taken, input logic [1:0] cnt);
		if (taken)
			return (cnt == 2'd3) ? cnt : cnt + 2'd1;
		else
			return (cnt == 2'd0) ? cnt : cnt - 2'd1;
	endfunction

	// Invalid way first, then lower rank, way 0 on a tie
	function automatic logic pick_victim(input logic [1:0] rank0, input logic [1:0] rank1);
		if (rank0 == 2'd0)
			return 1'b0;
		else if (rank1 == 2'd0)
			return 1'b1;
		else
			return (rank0 <= rank1) ? 1'b0 : 1'b1;
	endfunction

	assign wr_a.raw = wr_inst_addr;
	assign sr_a.raw = search_addr;
	assign widx     = wr_a.f.index;
	assign sidx     = sr_a.f.index;

	// Write side lookup
	assign wr_hit0  = (rank_mem[0][widx] != 2'd0) && (tag_mem[0][widx] == wr_a.f.tag);
	assign wr_hit1  = (rank_mem[1][widx] != 2'd0) && (tag_mem[1][widx] == wr_a.f.tag);
	assign wr_match = wr_hit0 || wr_hit1;

	always_comb begin
		if (wr_hit0)
			wr_way = 1'b0;
		else if (wr_hit1)
			wr_way = 1'b1;
		else
			wr_way = pick_victim(rank_mem[0][widx], rank_mem[1][widx]);
		if (wr_match)
			wr_cnt = cnt_step(wr_taken, cnt_mem[wr_way][widx]);
		else
			wr_cnt = wr_taken ? bp_pkg::CNT_WEAK_TAKEN : bp_pkg::CNT_WEAK_NOT;
	end

	// Search side lookup, way 0 checked first
	assign s_hit0   = (rank_mem[0][sidx] != 2'd0) && (tag_mem[0][sidx] == sr_a.f.tag);
	assign s_hit1   = (rank_mem[1][sidx] != 2'd0) && (tag_mem[1][sidx] == sr_a.f.tag);
	assign s_hit    = s_hit0 || s_hit1;
	assign s_way    = !s_hit0;
	assign same_set = wr_stb && (widx == sidx);

	assign age = &lru_timer;

	// Ranks and aging timer
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lru_timer <= '0;
			for (int w = 0; w < 2; w++)
				for (int s = 0; s < NUM_SETS; s++)
					rank_mem[w][s] <= 2'd0;
		end else if (flush) begin
			lru_timer <= '0;
			for (int w = 0; w < 2; w++)
				for (int s = 0; s < NUM_SETS; s++)
					rank_mem[w][s] <= 2'd0;
		end else begin
			lru_timer <= lru_timer + 1'b1;
			for (int w = 0; w < 2; w++) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					if (wr_stb && s == int'(widx) && w == int'(wr_way)) begin
						rank_mem[w][s] <= 2'd3;
					end else if (search_stb && s_hit && !same_set &&
							s == int'(sidx) && w == int'(s_way)) begin
						// Rank 3 holds, 1 and 2 move up
						if (rank_mem[w][s] == 2'd1 || rank_mem[w][s] == 2'd2)
							rank_mem[w][s] <= rank_mem[w][s] + 2'd1;
					end else if (age && rank_mem[w][s] >= 2'd2) begin
						rank_mem[w][s] <= rank_mem[w][s] - 2'd1;
					end
				end
			end
		end
	end

	// Entry payload
	always_ff @(posedge iCLOCK) begin
		if (wr_stb) begin
			tag_mem[wr_way][widx]    <= wr_a.f.tag;
			cnt_mem[wr_way][widx]    <= wr_cnt;
			target_mem[wr_way][widx] <= wr_target;
		end
	end

	// Registered search result
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			hit_q <= 1'b0;
		else
			hit_q <= search_stb && s_hit;
	end

	always_ff @(posedge iCLOCK) begin
		if (search_stb) begin
			taken_q  <= cnt_mem[s_way][sidx][1];
			target_q <= target_mem[s_way][sidx];
		end
	end

	// The two ways of a set never hold the same valid tag
	for (genvar s = 0; s < NUM_SETS; s++) begin : g_dup_chk
		a_no_dup_tag: assert property (@(posedge iCLOCK) disable iff (!inRESET)
			!(rank_mem[0][s] != 2'd0 && rank_mem[1][s] != 2'd0 &&
			tag_mem[0][s] == tag_mem[1][s]));
	end

endmodule

/* branch_update_queue.sv */
/*
 * Update queue between execute and the branch target cache.
 * Resolved branches are pushed on the valid/ready handshake and the
 * head entry is offered to the cache as a write strobe, one per cycle.
 */

`timescale 1ns/1ps

module branch_update_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        flush,
	input  logic        update_valid,
	input  logic [31:0] update_inst_addr,
	input  logic [31:0] update_target,
	input  logic        update_taken,
	output logic        update_ready,
	output logic        wr_stb,
	output logic [31:0] wr_inst_addr,
	output logic [31:0] wr_target,
	output logic        wr_taken
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Entry storage
	bp_pkg::fetch_addr_u addr_mem [QUEUE_DEPTH];
	logic [31:0]         target_mem [QUEUE_DEPTH];
	logic                taken_mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             ready_q;
	logic             push;
	logic             pop;

	assign push = update_valid && ready_q;
	// Cache takes the head every cycle it is offered
	assign pop  = (count != '0);

	always_comb begin
		count_next = count;
		case ({push, pop})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			ready_q <= 1'b0;
		end else if (flush) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			ready_q <= 1'b1;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count   <= count_next;
			// Ready for the next cycle only with a free slot
			ready_q <= (count_next < CNT_W'(QUEUE_DEPTH));
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			addr_mem[wr_ptr].raw <= update_inst_addr;
			target_mem[wr_ptr]   <= update_target;
			taken_mem[wr_ptr]    <= update_taken;
		end
	end

	assign update_ready = ready_q;
	assign wr_stb       = pop;
	assign wr_inst_addr = addr_mem[rd_ptr].raw;
	assign wr_target    = target_mem[rd_ptr];
	assign wr_taken     = taken_mem[rd_ptr];

	// Occupancy stays within the buffer
	a_count_bound: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		count <= CNT_W'(QUEUE_DEPTH));

endmodule

/* next_fetch_select.sv */
/*
 * Next fetch address selection.
 * Holds the search address for one cycle so it lines up with the
 * registered cache result, then picks the target or the next word.
 */

`timescale 1ns/1ps

module next_fetch_select (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        search_stb,
	input  logic [31:0] search_addr,
	input  logic        hit_q,
	input  logic        taken_q,
	input  logic [31:0] target_q,
	output logic        pred_valid,
	output logic        pred_hit,
	output logic        pred_taken,
	output logic [31:0] pred_next_addr
);

	logic                stb_q;
	logic [31:0]         addr_q;
	bp_pkg::fetch_addr_u seq_addr;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			stb_q <= 1'b0;
		else
			stb_q <= search_stb;
	end

	always_ff @(posedge iCLOCK) begin
		if (search_stb)
			addr_q <= search_addr;
	end

	// Sequential fetch, word aligned
	always_comb begin
		seq_addr.raw      = addr_q + 32'd4;
		seq_addr.f.offset = '0;
	end

	assign pred_valid     = stb_q;
	assign pred_hit       = hit_q;
	assign pred_taken     = hit_q && taken_q;
	assign pred_next_addr = (hit_q && taken_q) ? target_q : seq_addr.raw;

	// Cache result only ever comes with a search
	a_hit_needs_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		pred_hit |-> pred_valid);

endmodule

/* sources.f */
bp_pkg.sv
branch_update_queue.sv
branch_target_cache.sv
next_fetch_select.sv
branch_predict_top.sv
tb_checker.sv
tb_branch_predict.sv

/* tb_branch_predict.sv */
/*
 * Testbench top for the branch prediction subsystem.
 * Drives updates, searches and flushes on the falling edge; the
 * checker module compares results and this module reports the outcome.
 */

`timescale 1ns/1ps

module tb_branch_predict;

	localparam int RESET_CYCLES    = 10;
	localparam int RANDOM_SEARCHES = 16;
	localparam int BURST_N         = 12;
	// Directed steps add about 30 operations
	localparam int OP_COUNT        = RANDOM_SEARCHES + 3 * BURST_N + 30;

	logic        iCLOCK;
	logic        inRESET;
	logic        flush;
	logic        update_valid;
	logic [31:0] update_inst_addr;
	logic [31:0] update_target;
	logic        update_taken;
	logic        update_ready;
	logic        search_stb;
	logic [31:0] search_addr;
	logic        pred_valid;
	logic        pred_hit;
	logic        pred_taken;
	logic [31:0] pred_next_addr;
	int          value_errs;
	int          other_errs;

	logic [15:0] lfsr = 16'd16389;
	logic [31:0] addr_tab [4];
	logic [31:0] burst_addr [BURST_N];
	logic [31:0] extra_addr;

	branch_predict_top DUT (
		.iCLOCK           (iCLOCK),
		.inRESET          (inRESET),
		.flush            (flush),
		.update_valid     (update_valid),
		.update_inst_addr (update_inst_addr),
		.update_target    (update_target),
		.update_taken     (update_taken),
		.update_ready     (update_ready),
		.search_stb       (search_stb),
		.search_addr      (search_addr),
		.pred_valid       (pred_valid),
		.pred_hit         (pred_hit),
		.pred_taken       (pred_taken),
		.pred_next_addr   (pred_next_addr)
	);

	tb_checker u_checker (
		.iCLOCK           (iCLOCK),
		.inRESET          (inRESET),
		.flush            (flush),
		.update_valid     (update_valid),
		.update_ready     (update_ready),
		.update_inst_addr (update_inst_addr),
		.update_target    (update_target),
		.update_taken     (update_taken),
		.wr_stb           (DUT.wr_stb),
		.search_stb       (search_stb),
		.search_addr      (search_addr),
		.pred_valid       (pred_valid),
		.pred_hit         (pred_hit),
		.pred_taken       (pred_taken),
		.pred_next_addr   (pred_next_addr),
		.value_errs       (value_errs),
		.other_errs       (other_errs)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #10 iCLOCK = ~iCLOCK;
	end

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic next_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	// Random tag in a chosen set
	function automatic logic [31:0] make_addr(input int idx);
		logic [31:0] t;
		t = rand_bits(27);
		return {t[26:0], idx[2:0], 2'b00};
	endfunction

	// Tasks start and end just after a falling edge
	task automatic idle(input int n);
		repeat (n) @(negedge iCLOCK);
	endtask

	task automatic push_update(input logic [31:0] addr, input logic [31:0] target,
			input logic taken);
		update_valid     = 1'b1;
		update_inst_addr = addr;
		update_target    = target;
		update_taken     = taken;
		while (!update_ready)
			@(negedge iCLOCK);
		@(negedge iCLOCK);
		update_valid = 1'b0;
	endtask

	task automatic issue_search(input logic [31:0] addr);
		search_stb  = 1'b1;
		search_addr = addr;
		@(negedge iCLOCK);
		search_stb = 1'b0;
	endtask

	task automatic pulse_flush();
		flush = 1'b1;
		@(negedge iCLOCK);
		flush = 1'b0;
	endtask

	initial begin
		inRESET          = 1'b0;
		flush            = 1'b0;
		update_valid     = 1'b0;
		update_inst_addr = '0;
		update_target    = '0;
		update_taken     = 1'b0;
		search_stb       = 1'b0;
		search_addr      = '0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		@(negedge iCLOCK);
		// Offered while ready is still low after reset, must be dropped
		extra_addr       = make_addr(7);
		inRESET          = 1'b1;
		update_valid     = 1'b1;
		update_inst_addr = extra_addr;
		update_target    = rand_bits(32);
		update_taken     = 1'b1;
		@(negedge iCLOCK);
		update_valid = 1'b0;
		idle(2);
		issue_search(extra_addr);
		for (int i = 0; i < RANDOM_SEARCHES; i++)
			issue_search(rand_bits(32));

		// Sets 1, 2, 3 and a second tag in set 1
		for (int i = 0; i < 4; i++)
			addr_tab[i] = make_addr((i == 3) ? 1 : i + 1);
		push_update(addr_tab[0], rand_bits(30) << 2, 1'b1);
		push_update(addr_tab[1], rand_bits(30) << 2, 1'b0);
		idle(2);
		issue_search(addr_tab[0]);
		issue_search(addr_tab[1]);

		// Counter walk: taken, not, not, taken, taken
		for (int i = 0; i < 5; i++) begin
			push_update(addr_tab[2], rand_bits(30) << 2, (i == 0) || (i > 2));
			idle(2);
			issue_search(addr_tab[2]);
		end

		push_update(addr_tab[3], rand_bits(30) << 2, 1'b1);
		idle(2);
		issue_search(addr_tab[0]);
		issue_search(addr_tab[3]);
		issue_search(make_addr(1));

		// Flush lands while this update sits in the queue and a copy is on the port
		extra_addr = make_addr(5);
		push_update(extra_addr, rand_bits(30) << 2, 1'b1);
		update_valid = 1'b1;
		pulse_flush();
		update_valid = 1'b0;
		idle(2);
		for (int i = 0; i < 4; i++)
			issue_search(addr_tab[i]);
		issue_search(extra_addr);

		// Back-to-back updates with searches running alongside
		for (int i = 0; i < BURST_N; i++)
			burst_addr[i] = make_addr(i % 8);
		for (int i = 0; i < BURST_N; i++) begin
			update_valid     = 1'b1;
			update_inst_addr = burst_addr[i];
			update_target    = rand_bits(30) << 2;
			update_taken     = next_bit();
			search_stb       = (i >= 3);
			search_addr      = burst_addr[(i >= 3) ? i - 3 : 0];
			@(negedge iCLOCK);
		end
		update_valid = 1'b0;
		search_stb   = 1'b0;
		idle(3);
		for (int i = 0; i < BURST_N; i++)
			issue_search(burst_addr[i]);
		idle(3);

		$display("Errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		repeat (OP_COUNT * 20 + 500) @(posedge iCLOCK);
		$display("Watchdog expired after %0d cycles, the tests did not finish",
			OP_COUNT * 20 + 500);
		$display("Errors: %0d value, %0d other", value_errs, other_errs);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* tb_checker.sv */
/*
 * Checker for the branch predictor testbench.
 * Follows accepted updates through a model of the queue and the cache,
 * then compares the ready flag and every search result with it.
 */

`timescale 1ns/1ps

module tb_checker #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        flush,
	input  logic        update_valid,
	input  logic        update_ready,
	input  logic [31:0] update_inst_addr,
	input  logic [31:0] update_target,
	input  logic        update_taken,
	input  logic        wr_stb,
	input  logic        search_stb,
	input  logic [31:0] search_addr,
	input  logic        pred_valid,
	input  logic        pred_hit,
	input  logic        pred_taken,
	input  logic [31:0] pred_next_addr,
	output int          value_errs,
	output int          other_errs
);

	logic        m_valid  [2][8];
	logic [26:0] m_tag    [2][8];
	logic [1:0]  m_cnt    [2][8];
	logic [31:0] m_target [2][8];
	// Accepted updates on their way to the cache, packed as addr, target, taken
	logic [64:0] pending [$];
	logic [64:0] head;
	logic        active = 1'b0;
	logic        exp_ready = 1'b0;
	logic        exp_valid = 1'b0;
	logic        exp_hit = 1'b0;
	logic        exp_taken;
	logic [31:0] exp_next;
	logic        hit0;
	logic        hit1;
	int          sidx;
	int          way;
	int          n_value = 0;
	int          n_other = 0;

	assign value_errs = n_value;
	assign other_errs = n_other;

	// Taken hit follows the target, anything else the next word
	function automatic logic [31:0] expected_next(input logic [31:0] addr,
			input logic taken_hit, input logic [31:0] target);
		if (taken_hit)
			return target;
		return (addr + 32'd4) & 32'hffff_fffc;
	endfunction

	task automatic clear_model();
		for (int w = 0; w < 2; w++)
			for (int s = 0; s < 8; s++)
				m_valid[w][s] = 1'b0;
		pending.delete();
	endtask

	function automatic void model_write(input logic [31:0] addr, input logic [31:0] target,
			input logic taken);
		int s;
		int w;
		s = int'(addr[4:2]);
		if (m_valid[0][s] && m_tag[0][s] == addr[31:5])
			w = 0;
		else if (m_valid[1][s] && m_tag[1][s] == addr[31:5])
			w = 1;
		else
			w = -1;
		if (w >= 0) begin
			if (taken && m_cnt[w][s] != 2'd3)
				m_cnt[w][s] = m_cnt[w][s] + 2'd1;
			else if (!taken && m_cnt[w][s] != 2'd0)
				m_cnt[w][s] = m_cnt[w][s] - 2'd1;
		end else begin
			w = m_valid[0][s] ? 1 : 0;
			if (m_valid[0][s] && m_valid[1][s]) begin
				$display("Third tag written to set %0d, victim depends on LRU ranks", s);
				n_other++;
			end
			m_valid[w][s] = 1'b1;
			m_tag[w][s]   = addr[31:5];
			m_cnt[w][s]   = taken ? 2'd2 : 2'd1;
		end
		m_target[w][s] = target;
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("CHECK FAILED %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
		n_value++;
	endtask

	always @(posedge iCLOCK) begin
		active = inRESET;
		if (!inRESET) begin
			clear_model();
			exp_ready = 1'b0;
			exp_valid = 1'b0;
			exp_hit   = 1'b0;
		end else begin
			// Search sees the contents from before this edge
			sidx      = int'(search_addr[4:2]);
			hit0      = m_valid[0][sidx] && m_tag[0][sidx] == search_addr[31:5];
			hit1      = m_valid[1][sidx] && m_tag[1][sidx] == search_addr[31:5];
			way       = hit0 ? 0 : 1;
			exp_valid = search_stb;
			exp_hit   = search_stb && (hit0 || hit1);
			exp_taken = exp_hit && m_cnt[way][sidx][1];
			exp_next  = expected_next(search_addr, exp_taken, m_target[way][sidx]);
			if (wr_stb && pending.size() == 0) begin
				$display("Cache write strobe with no accepted update waiting at %0t", $time);
				n_other++;
			end else if (!wr_stb && pending.size() != 0) begin
				$display("Accepted update not offered to the cache at %0t", $time);
				n_other++;
			end else if (wr_stb) begin
				head = pending.pop_front();
				model_write(head[64:33], head[32:1], head[0]);
			end
			if (flush)
				clear_model();
			else if (update_valid && exp_ready)
				pending.push_back({update_inst_addr, update_target, update_taken});
			exp_ready = pending.size() < QUEUE_DEPTH;
		end
	end

	// Outputs are settled half a cycle after the edge
	always @(negedge iCLOCK) begin
		if (active) begin
			if (update_ready !== exp_ready)
				report_value("update_ready", exp_ready, update_ready);
			if (pred_valid !== exp_valid)
				report_value("pred_valid", exp_valid, pred_valid);
			if (pred_hit !== exp_hit)
				report_value("pred_hit", exp_hit, pred_hit);
			if (exp_valid && pred_taken !== exp_taken)
				report_value("pred_taken", exp_taken, pred_taken);
			if (exp_valid && pred_next_addr !== exp_next)
				report_value("pred_next_addr", exp_next, pred_next_addr);
		end
	end

endmodule
